/* tcp_tx_testdata.txt */
# a: src_ip dst_ip src_port dst_port seq ack flags win urg payload_length payload_chsum
# b: mss_pres mss win_pres win_scale sack_pres ts_pres ts_val ts_ecr chsum frame_len
c0a80001 c0a80002 1234 0050 00000100 00000200 002 1000 0000 0000 00000000
0 0000 0 00 0 0 00000000 00000000 090b 0014

0a000001 0a000002 8000 0016 000003fe 00000001 018 2000 0000 0004 0000ff00
1 05b4 0 00 0 0 00000000 00000000 e0f3 001c

c0a80001 c0a80002 1234 0050 00000010 00000020 010 ffff 0000 0003 0000924b
1 05b4 1 07 1 1 0000abcd 00000000 63c8 002f

0a000001 0a000002 8000 0016 00000200 00001000 010 0400 0005 0001 00005a00
0 0000 1 02 0 1 00001111 00002222 2b62 0025

01020304 05060708 0400 0401 12345678 9abcdef0 1ff 0000 ffff 0002 00002223
0 0000 0 00 1 0 00000000 00000000 7c4b 001a

/* verilog.f */
+incdir+.
tcp_tx_pkg.sv
tcp_opt_packer.sv
tcp_chsum_accum.sv
tcp_frame_serializer.sv
tcp_tx.sv
tcp_tx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tcp_tx_tb
FILELIST  := verilog.f

SRCS := $(shell grep -v '^+' $(FILELIST)) tcp_tx_params.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) tcp_tx_testdata.txt
	./$(BIN)

clean:
	rm -rf obj_dir

/* tcp_tx_tb.sv */
`include "tcp_tx_params.svh"

module tcp_tx_tb;

  logic        clk;
  logic        fsm_rst;
  logic        start;
  logic [31:0] src_ip;
  logic [31:0] dst_ip;
  logic [15:0] src_port;
  logic [15:0] dst_port;
  logic [31:0] seq_num;
  logic [31:0] ack_num;
  logic [8:0]  flags;
  logic [15:0] win_size;
  logic [15:0] urg_ptr;
  logic [15:0] payload_length;
  logic [31:0] payload_chsum;
  logic        mss_pres;
  logic [15:0] mss;
  logic        win_pres;
  logic [7:0]  win_scale;
  logic        sack_perm_pres;
  logic        ts_pres;
  logic [31:0] ts_val;
  logic [31:0] ts_ecr;
  logic [7:0]  queue_data;
  logic [`TCP_TX_RAM_DEPTH-1:0] queue_addr;
  logic        queue_req;
  logic        busy;
  logic        tx_v;
  logic        tx_sof;
  logic        tx_eof;
  logic [7:0]  tx_d;

  logic [15:0] exp_chsum;   // from the data file
  logic [15:0] exp_len;
  logic [31:0] lcg_state;
  logic [7:0]  got[$];      // bytes seen on the wire
  logic [7:0]  exp[$];      // bytes built from the segment fields
  int          fd;
  int          nseg;

  tcp_tx dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // payload store, one cycle read latency
  always @(posedge clk) begin
    queue_data <= queue_addr[7:0] ^ 8'h5a;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] want,
                             input logic [31:0] seen);
    assert (want === seen) else
      stop_run($sformatf("** Error at time %0t: %s expected %h, got %h",
                         $time, name, want, seen));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic push16(input logic [15:0] w);
    exp.push_back(w[15:8]); // network order, high byte first
    exp.push_back(w[7:0]);
  endtask

  task automatic push32(input logic [31:0] w);
    push16(w[31:16]);
    push16(w[15:0]);
  endtask

  // frame as the wire should carry it
  task automatic build_expected;
    logic [3:0]  nwords;
    logic [31:0] addr;
    int          j;
    nwords = 4'(mss_pres) + 4'(win_pres) + 4'(sack_perm_pres) + 4'(3 * ts_pres);
    exp.delete();
    push16(src_port);
    push16(dst_port);
    push32(seq_num);
    push32(ack_num);
    push16({4'd5 + nwords, 3'b000, flags}); // offset nibble counts 32-bit words
    push16(win_size);
    push16(exp_chsum);
    push16(urg_ptr);
    if (mss_pres) push32({8'd2, 8'd4, mss});
    if (win_pres) push32({8'd1, 8'd3, 8'd3, win_scale});
    if (sack_perm_pres) push32({8'd1, 8'd1, 8'd4, 8'd2});
    if (ts_pres) begin
      push32({8'd1, 8'd1, 8'd8, 8'd10});
      push32(ts_val);
      push32(ts_ecr);
    end
    for (j = 0; j < int'(payload_length); j++) begin
      addr = (seq_num + 32'(j)) % 32'(1 << `TCP_TX_RAM_DEPTH); // store wraps
      exp.push_back(addr[7:0] ^ 8'h5a);
    end
  endtask

  task automatic run_segment;
    int          cnt;
    int          i;
    int          nxt;
    int          hdr_bytes;
    logic        want_req;
    int unsigned gap;
    start = 1'b1; // inputs were set on this falling edge
    @(negedge clk);
    start = 1'b0;
    check_value("busy", 32'd1, 32'(busy));
    repeat (3) @(negedge clk);
    start = 1'b1; // ignored, engine is busy
    @(negedge clk);
    start = 1'b0;
    cnt = 0;
    while (!tx_v) begin
      check_value("busy", 32'd1, 32'(busy));
      check_value("queue_req", 32'd0, 32'(queue_req));
      @(negedge clk);
      cnt++;
      if (cnt > 100) stop_run("timeout waiting for the first frame byte");
    end
    hdr_bytes = int'(exp_len) - int'(payload_length); // header plus options
    got.delete();
    while (1) begin
      nxt = got.size() + 1; // byte whose store address goes out now
      want_req = (nxt >= hdr_bytes) && (nxt < int'(exp_len));
      check_value("tx_v", 32'd1, 32'(tx_v)); // no gaps inside the frame
      check_value("busy", 32'd1, 32'(busy));
      check_value("tx_sof", 32'(got.size() == 0), 32'(tx_sof));
      check_value("queue_req", 32'(want_req), 32'(queue_req));
      if (want_req) begin
        check_value("queue_addr",
                    (seq_num + 32'(nxt - hdr_bytes)) % 32'(1 << `TCP_TX_RAM_DEPTH),
                    32'(queue_addr));
      end
      got.push_back(tx_d);
      if (tx_eof) break;
      if (got.size() > 2000) stop_run("timeout waiting for the last frame byte");
      @(negedge clk);
    end
    @(negedge clk);
    check_value("busy", 32'd0, 32'(busy)); // drops the cycle after tx_eof
    check_value("tx_v", 32'd0, 32'(tx_v));
    // the second start must not have queued another frame
    repeat (20) begin
      @(negedge clk);
      check_value("tx_v", 32'd0, 32'(tx_v));
      check_value("busy", 32'd0, 32'(busy));
      check_value("queue_req", 32'd0, 32'(queue_req));
    end
    build_expected();
    check_value("frame length", 32'(exp_len), 32'(got.size()));
    check_value("built length", 32'(exp_len), 32'(exp.size()));
    for (i = 0; i < exp.size(); i++) begin
      check_value($sformatf("tx_d byte %0d", i), 32'(exp[i]), 32'(got[i]));
    end
    lcg_state = lcg_next(lcg_state);
    gap = (lcg_state >> 16) % 8; // idle cycles before next segment
    repeat (gap) @(negedge clk);
  endtask

  initial begin
    string line;
    int    n;
    fsm_rst = 1'b1;
    start = 1'b0;
    src_ip = '0;
    dst_ip = '0;
    src_port = '0;
    dst_port = '0;
    seq_num = '0;
    ack_num = '0;
    flags = '0;
    win_size = '0;
    urg_ptr = '0;
    payload_length = '0;
    payload_chsum = '0;
    mss_pres = 1'b0;
    mss = '0;
    win_pres = 1'b0;
    win_scale = '0;
    sack_perm_pres = 1'b0;
    ts_pres = 1'b0;
    ts_val = '0;
    ts_ecr = '0;
    queue_data <= '0; // store output before the first read
    lcg_state = 32'd40;
    nseg = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    @(negedge clk);
    // everything quiet out of reset
    check_value("tx_v", 32'd0, 32'(tx_v));
    check_value("tx_sof", 32'd0, 32'(tx_sof));
    check_value("tx_eof", 32'd0, 32'(tx_eof));
    check_value("queue_req", 32'd0, 32'(queue_req));
    check_value("busy", 32'd0, 32'(busy));
    fd = $fopen("tcp_tx_testdata.txt", "r");
    if (fd == 0) stop_run("cannot open tcp_tx_testdata.txt");
    n = $fgets(line, fd); // two column description lines
    n = $fgets(line, fd);
    while (1) begin
      n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", src_ip, dst_ip,
                  src_port, dst_port, seq_num, ack_num, flags, win_size,
                  urg_ptr, payload_length, payload_chsum);
      if (n != 11) break;
      n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", mss_pres, mss, win_pres,
                  win_scale, sack_perm_pres, ts_pres, ts_val, ts_ecr,
                  exp_chsum, exp_len);
      if (n != 10) stop_run("segment in the data file has no option line");
      run_segment();
      nseg++;
    end
    $fclose(fd);
    if (nseg == 0) begin
      stop_run("no segments found in the data file");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

/* tcp_tx.sv */
`include "tcp_tx_params.svh"

module tcp_tx import tcp_tx_pkg::*; (
  input  logic                         clk,
  input  logic                         fsm_rst,
  input  logic                         start,
  input  logic [31:0]                  src_ip,
  input  logic [31:0]                  dst_ip,
  input  logic [15:0]                  src_port,
  input  logic [15:0]                  dst_port,
  input  logic [31:0]                  seq_num,
  input  logic [31:0]                  ack_num,
  input  logic [8:0]                   flags,
  input  logic [15:0]                  win_size,
  input  logic [15:0]                  urg_ptr,
  input  logic [15:0]                  payload_length,
  input  logic [31:0]                  payload_chsum,
  input  logic                         mss_pres,
  input  logic [15:0]                  mss,
  input  logic                         win_pres,
  input  logic [7:0]                   win_scale,
  input  logic                         sack_perm_pres,
  input  logic                         ts_pres,
  input  logic [31:0]                  ts_val,
  input  logic [31:0]                  ts_ecr,
  input  logic [7:0]                   queue_data,
  output logic [`TCP_TX_RAM_DEPTH-1:0] queue_addr,
  output logic                         queue_req,
  output logic                         busy,
  output logic                         tx_v,
  output logic                         tx_sof,
  output logic                         tx_eof,
  output logic [7:0]                   tx_d
);

  logic [0:`TCP_MAX_OPT_WORDS-1][31:0] opt_block;
  logic [2:0]                          opt_words;
  chsum_t                              opt_sum;
  chsum_t                              base_sum;
  logic                                opt_done;
  logic                                sum_done;
  logic                                clear;

  tcp_opt_packer u_packer (
    .clk, .fsm_rst, .start, .clear,
    .mss_pres, .mss, .win_pres, .win_scale, .sack_perm_pres,
    .ts_pres, .ts_val, .ts_ecr,
    .opt_block, .opt_words, .opt_sum, .opt_done
  );

  tcp_chsum_accum u_accum (
    .clk, .fsm_rst, .start, .clear,
    .src_ip, .dst_ip, .src_port, .dst_port, .seq_num, .ack_num,
    .flags, .win_size, .urg_ptr, .payload_length, .payload_chsum,
    .base_sum, .sum_done
  );

  tcp_frame_serializer u_ser (
    .clk, .fsm_rst, .start, .opt_done, .sum_done,
    .opt_block, .opt_words, .opt_sum, .base_sum,
    .src_port, .dst_port, .seq_num, .ack_num, .flags, .win_size, .urg_ptr,
    .payload_length, .queue_data,
    .clear, .busy, .queue_addr, .queue_req,
    .tx_v, .tx_sof, .tx_eof, .tx_d
  );

endmodule

/* tcp_frame_serializer.sv */
`include "tcp_tx_params.svh"

module tcp_frame_serializer import tcp_tx_pkg::*; (
  input  logic                                clk,
  input  logic                                fsm_rst,
  input  logic                                start,
  input  logic                                opt_done,
  input  logic                                sum_done,
  input  logic [0:`TCP_MAX_OPT_WORDS-1][31:0] opt_block,
  input  logic [2:0]                          opt_words,
  input  chsum_t                              opt_sum,
  input  chsum_t                              base_sum,
  input  logic [15:0]                         src_port,
  input  logic [15:0]                         dst_port,
  input  logic [31:0]                         seq_num,
  input  logic [31:0]                         ack_num,
  input  logic [8:0]                          flags,
  input  logic [15:0]                         win_size,
  input  logic [15:0]                         urg_ptr,
  input  logic [15:0]                         payload_length,
  input  logic [7:0]                          queue_data,
  output logic                                clear,
  output logic                                busy,
  output logic [`TCP_TX_RAM_DEPTH-1:0]        queue_addr,
  output logic                                queue_req,
  output logic                                tx_v,
  output logic                                tx_sof,
  output logic                                tx_eof,
  output logic [7:0]                          tx_d
);

  localparam int HDR_BYTES = `TCP_MIN_HDR_LEN + 4 * `TCP_MAX_OPT_WORDS;

  tx_state_e state;

  logic [0:HDR_BYTES-1][7:0] hdr_sr;   // byte 0 is on the wire
  logic [15:0]               chsum;
  logic                      sums_ok;  // checksum registered, header load next
  logic [16:0]               byte_cnt; // index of the byte now on tx_d
  logic [16:0]               hdr_len;
  logic [16:0]               frame_len;
  logic [3:0]                offset;
  chsum_t                    sum_all;
  logic [16:0]               fold1;
  logic [15:0]               fold2;

  assign busy = (state != IDLE);

  assign offset    = 4'(`TCP_MIN_HDR_LEN / 4) + {1'b0, opt_words};
  assign hdr_len   = 17'(`TCP_MIN_HDR_LEN) + 17'({opt_words, 2'b00});
  assign frame_len = hdr_len + 17'(payload_length);

  // end-around carry, second fold catches the carry of the first
  assign sum_all = base_sum + opt_sum;
  assign fold1   = {1'b0, sum_all[31:16]} + {1'b0, sum_all[15:0]};
  assign fold2   = fold1[15:0] + {15'h0000, fold1[16]};

  // store data lines up with the address issued a cycle earlier
  assign tx_d = (state == PAYLOAD) ? queue_data : hdr_sr[0];

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= IDLE;
      sums_ok   <= 1'b0;
      byte_cnt  <= '0;
      clear     <= 1'b0;
      queue_req <= 1'b0;
      tx_v      <= 1'b0;
      tx_sof    <= 1'b0;
      tx_eof    <= 1'b0;
    end else begin
      clear <= 1'b0; // single cycle pulse
      case (state)
        IDLE: begin
          sums_ok <= 1'b0;
          if (start) state <= WAIT_SUMS;
        end
        WAIT_SUMS: begin
          if (!sums_ok) begin
            if (opt_done && sum_done) begin
              chsum   <= ~fold2;
              sums_ok <= 1'b1;
            end
          end else begin
            // whole header plus all option slots, only hdr_len bytes go out
            hdr_sr <= {src_port, dst_port, seq_num, ack_num,
                       offset, 3'b000, flags, win_size, chsum, urg_ptr,
                       opt_block};
            queue_addr <= seq_num[`TCP_TX_RAM_DEPTH-1:0]; // wraps on store depth
            byte_cnt   <= '0;
            tx_v       <= 1'b1;
            tx_sof     <= 1'b1;
            tx_eof     <= 1'b0;
            state      <= HDR;
          end
        end
        HDR, PAYLOAD: begin
          tx_sof   <= 1'b0;
          byte_cnt <= byte_cnt + 17'd1;
          hdr_sr[0:HDR_BYTES-2] <= hdr_sr[1:HDR_BYTES-1];
          if (queue_req) queue_addr <= queue_addr + 1'b1;
          // address runs one byte ahead of the output
          queue_req <= (byte_cnt + 17'd2 >= hdr_len) && (byte_cnt + 17'd2 < frame_len);
          tx_eof    <= (byte_cnt + 17'd2 == frame_len);
          if (tx_eof) begin // last byte this cycle
            tx_v      <= 1'b0;
            tx_eof    <= 1'b0;
            queue_req <= 1'b0;
            clear     <= 1'b1;
            state     <= IDLE;
          end else if (state == HDR && byte_cnt + 17'd1 == hdr_len) begin
            state <= PAYLOAD;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* tcp_chsum_accum.sv */
`include "tcp_tx_params.svh"

module tcp_chsum_accum import tcp_tx_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        start,
  input  logic        clear,
  input  logic [31:0] src_ip,
  input  logic [31:0] dst_ip,
  input  logic [15:0] src_port,
  input  logic [15:0] dst_port,
  input  logic [31:0] seq_num,
  input  logic [31:0] ack_num,
  input  logic [8:0]  flags,
  input  logic [15:0] win_size,
  input  logic [15:0] urg_ptr,
  input  logic [15:0] payload_length,
  input  logic [31:0] payload_chsum,
  output chsum_t      base_sum,
  output logic        sum_done
);

  localparam int NWORDS = 16; // 6 pseudo header words + 10 header words

  logic [0:NWORDS-1][15:0] words;
  logic [3:0]              word_cnt;
  logic                    run;
  logic                    start_ok;
  logic [15:0]             tcp_len;

  // options add their share in the packer
  assign tcp_len = payload_length + 16'(`TCP_MIN_HDR_LEN);

  assign start_ok = start && (!(run || sum_done) || clear);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      run      <= 1'b0;
      sum_done <= 1'b0;
      word_cnt <= '0;
      base_sum <= '0;
    end else if (start_ok) begin
      words <= {
        src_ip,                      // pseudo header
        dst_ip,
        8'h00, `TCP_PROTO,
        tcp_len,
        src_port,                    // fixed header
        dst_port,
        seq_num,
        ack_num,
        4'h0, 3'b000, flags,         // offset nibble counted by the packer
        win_size,
        16'h0000,                    // checksum slot
        urg_ptr
      };
      base_sum <= payload_chsum;     // payload already summed upstream
      word_cnt <= '0;
      run      <= 1'b1;
      sum_done <= 1'b0;
    end else if (clear) begin
      run      <= 1'b0;
      sum_done <= 1'b0;
      base_sum <= '0;
    end else if (run) begin
      base_sum <= base_sum + chsum_t'(words[0]);
      words[0:NWORDS-2] <= words[1:NWORDS-1]; // next word to the head
      word_cnt <= word_cnt + 4'd1;
      if (word_cnt == 4'(NWORDS - 1)) begin
        run      <= 1'b0;
        sum_done <= 1'b1; // holds until clear
      end
    end
  end

endmodule

/* tcp_opt_packer.sv */
`include "tcp_tx_params.svh"

module tcp_opt_packer import tcp_tx_pkg::*; (
  input  logic                                    clk,
  input  logic                                    fsm_rst,
  input  logic                                    start,
  input  logic                                    clear,
  input  logic                                    mss_pres,
  input  logic [15:0]                             mss,
  input  logic                                    win_pres,
  input  logic [7:0]                              win_scale,
  input  logic                                    sack_perm_pres,
  input  logic                                    ts_pres,
  input  logic [31:0]                             ts_val,
  input  logic [31:0]                             ts_ecr,
  output logic [0:`TCP_MAX_OPT_WORDS-1][31:0]     opt_block,
  output logic [2:0]                              opt_words,
  output chsum_t                                  opt_sum,
  output logic                                    opt_done
);

  // one template slot per possible option word
  logic [0:`TCP_MAX_OPT_WORDS-1][31:0] proto;
  logic [0:`TCP_MAX_OPT_WORDS-1]       pres;
  logic [2:0]                          step;     // template index being looked at
  logic                                shifting;
  logic                                start_ok;
  logic [2:0]                          words_nxt;
  chsum_t                              word_term;
  chsum_t                              hdr_terms;

  // start while a segment is in flight is dropped, except on the clear cycle
  assign start_ok = start && (!(shifting || opt_done) || clear);

  assign words_nxt = opt_words + {2'b00, pres[0]};

  // both 16-bit halves of the word at the head of the template
  assign word_term = pres[0] ? chsum_t'(proto[0][31:16]) + chsum_t'(proto[0][15:0]) : '0;

  // data offset nibble lands in the top of header word 6
  // plus option share of the pseudo header length
  assign hdr_terms = chsum_t'({4'(`TCP_MIN_HDR_LEN / 4) + {1'b0, words_nxt}, 12'h000}) +
                     chsum_t'({words_nxt, 2'b00});

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      shifting  <= 1'b0;
      opt_done  <= 1'b0;
      opt_words <= '0;
      opt_sum   <= '0;
      step      <= '0;
    end else if (start_ok) begin
      // every option we may send, in wire order
      proto <= {
        {OPT_MSS, 8'd4, mss},
        {OPT_NOP, OPT_WIN, 8'd3, win_scale},
        {OPT_NOP, OPT_NOP, OPT_SACK_PERM, 8'd2},
        {OPT_NOP, OPT_NOP, OPT_TIMESTAMP, 8'd10},
        ts_val,
        ts_ecr
      };
      pres      <= {mss_pres, win_pres, sack_perm_pres, {3{ts_pres}}};
      opt_block <= '0;
      opt_words <= '0;
      opt_sum   <= '0;
      step      <= '0;
      shifting  <= 1'b1;
      opt_done  <= 1'b0;
    end else if (clear) begin // frame sent, back to idle
      shifting  <= 1'b0;
      opt_done  <= 1'b0;
      opt_words <= '0;
      opt_sum   <= '0;
    end else if (shifting) begin
      step <= step + 3'd1;
      proto[0:`TCP_MAX_OPT_WORDS-2] <= proto[1:`TCP_MAX_OPT_WORDS-1];
      pres[0:`TCP_MAX_OPT_WORDS-2]  <= pres[1:`TCP_MAX_OPT_WORDS-1];
      if (pres[0]) begin
        opt_block[opt_words] <= proto[0]; // append behind the words already packed
      end
      opt_words <= words_nxt;
      if (step == 3'(`TCP_MAX_OPT_WORDS - 1)) begin
        opt_sum  <= opt_sum + word_term + hdr_terms; // last slot, close the sum
        opt_done <= 1'b1;
        shifting <= 1'b0;
      end else begin
        opt_sum <= opt_sum + word_term;
      end
    end
  end

endmodule

/* tcp_tx_pkg.sv */
package tcp_tx_pkg;

  // option kinds as they appear in the option block
  typedef enum logic [7:0] {
    OPT_EOL       = 8'd0,
    OPT_NOP       = 8'd1,
    OPT_MSS       = 8'd2,
    OPT_WIN       = 8'd3,
    OPT_SACK_PERM = 8'd4,
    OPT_TIMESTAMP = 8'd8
  } tcp_opt_kind_e;

  // serializer fsm
  typedef enum logic [1:0] {
    IDLE,      // waiting for start
    WAIT_SUMS, // packer and accumulator still busy
    HDR,       // header and options going out
    PAYLOAD    // bytes from the store
  } tx_state_e;

  // running one's complement sum, carries kept above bit 15
  typedef logic [31:0] chsum_t;

endpackage

/* tcp_tx_params.svh */
`ifndef TCP_TX_PARAMS_SVH
`define TCP_TX_PARAMS_SVH

// payload store address width, depth is 2**TCP_TX_RAM_DEPTH bytes
`define TCP_TX_RAM_DEPTH 10

// fixed tcp header, no options
`define TCP_MIN_HDR_LEN 20

// 32-bit option words, sack blocks not supported
`define TCP_MAX_OPT_WORDS 6

// ip protocol number for the pseudo header
`define TCP_PROTO 8'd6

`endif
